// ==== Bender.yml ====
package:
  name: stack_core

sources:
  - common/core_cfg_pkg.sv
  - common/core_isa_pkg.sv
  - stack/data_stack.sv
  - verilog/var_file.sv
  - verilog/core_alu.sv
  - sequencer/core_sequencer.sv
  - verilog/core_top.sv
  - target: simulation
    files:
      - bench/core_sva.sv
      - bench/tb_core.sv

// ==== bench/core_sva.sv ====
// concurrent checks on stack commands and error code stability, bound into core_sequencer
module core_sva (
	input logic clk,
	input logic rst_n,
	input logic i_push_en,
	input logic i_instr_en,
	input core_cfg_pkg::stack_cmd_t i_stack_cmd,
	input core_cfg_pkg::stack_stat_t i_stack_stat,
	input logic i_idle,
	input logic [core_isa_pkg::ERR_W-1:0] i_errcode
);

	int fail_count = 0;	// read by the testbench summary

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		(i_stack_cmd.op == core_cfg_pkg::PUSH) |-> !i_stack_stat.full)
		else begin
			$error("push issued to a full data stack");
			fail_count++;
		end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(i_stack_cmd.op == core_cfg_pkg::POP) |-> !i_stack_stat.empty)
		else begin
			$error("pop issued to an empty data stack");
			fail_count++;
		end

	// idle with no strobe means nothing can raise a new code
	a_errcode_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(i_idle && !i_push_en && !i_instr_en) |=> $stable(i_errcode))
		else begin
			$error("error code changed while the core was idle");
			fail_count++;
		end

endmodule

bind core_sequencer core_sva u_core_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.i_push_en    (i_push_en),
	.i_instr_en   (i_instr_en),
	.i_stack_cmd  (o_stack_cmd),
	.i_stack_stat (i_stack_stat),
	.i_idle       (o_idle),
	.i_errcode    (o_errcode)
);

// ==== bench/tb_core.sv ====
// testbench for core_top with clock, reset, stack model, directed tests, timeout and summary
module tb_core;

	localparam int CYCLE_LIMIT = 4000;	// full run needs well under 1000 cycles

	logic clk;
	logic rst_n;
	logic i_en;
	core_cfg_pkg::word_t i_push_value;
	logic i_push_en;
	core_isa_pkg::instr_t i_instr;
	logic i_instr_en;
	logic o_idle;
	logic [core_isa_pkg::ERR_W-1:0] o_errcode;
	logic [core_isa_pkg::TRACE_W-1:0] o_trace;

	core_cfg_pkg::word_t model [$];		// back of the queue is the top of the stack
	core_cfg_pkg::word_t var_model [core_cfg_pkg::VREGS];
	integer seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	core_top u_core_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_en         (i_en),
		.i_push_value (i_push_value),
		.i_push_en    (i_push_en),
		.i_instr      (i_instr),
		.i_instr_en   (i_instr_en),
		.o_idle       (o_idle),
		.o_errcode    (o_errcode),
		.o_trace      (o_trace)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the DUT did not return to idle within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp === act) else begin
			$display("ERR %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		model.delete();
		for (int i = 0; i < core_cfg_pkg::VREGS; i++) begin
			var_model[i] = '0;
		end
	endtask

	// called one time unit after an edge, returns at the same offset
	task automatic wait_idle();
		while (!o_idle) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic push_value(input core_cfg_pkg::word_t v);
		i_push_value = v;
		i_push_en = 1'b1;
		@(posedge clk);
		#1;
		i_push_en = 1'b0;
		wait_idle();
		if (model.size() < core_cfg_pkg::STACK_DEPTH) model.push_back(v);	// overflow is lost
	endtask

	task automatic run_word(input logic [6:0] lo, input logic [6:0] hi);
		i_instr.lo = lo;
		i_instr.hi = hi;
		i_instr_en = 1'b1;
		@(posedge clk);
		#1;
		i_instr_en = 1'b0;
		wait_idle();
	endtask

	function automatic core_cfg_pkg::word_t rand_word();
		return core_cfg_pkg::word_t'({$random(seed), $random(seed)});
	endfunction

	function automatic logic [7:0] expected_trace();
		if (model.size() == 0) return 8'hff;
		return model[model.size()-1][7:0];
	endfunction

	// a is the second item, b the top item or the only operand
	function automatic core_cfg_pkg::word_t model_result(input logic [6:0] op,
			input core_cfg_pkg::word_t a, input core_cfg_pkg::word_t b);
		case (op)
			core_isa_pkg::OP_INC: return b + 1;
			core_isa_pkg::OP_DEC: return b - 1;
			core_isa_pkg::OP_NOT: return ~b;
			core_isa_pkg::OP_COM: return 0 - b;
			core_isa_pkg::OP_ADD: return a + b;
			core_isa_pkg::OP_SUB: return a - b;
			core_isa_pkg::OP_AND: return a & b;
			core_isa_pkg::OP_OR:  return a | b;
			core_isa_pkg::OP_XOR: return a ^ b;
			core_isa_pkg::OP_EQ:  return (a == b) ? 1 : 0;
			core_isa_pkg::OP_NEQ: return (a != b) ? 1 : 0;
			core_isa_pkg::OP_GT:  return (a > b) ? 1 : 0;
			core_isa_pkg::OP_SM:  return (a < b) ? 1 : 0;
			default: return 0;
		endcase
	endfunction

	task automatic test_reset();
		apply_reset();
		check_equal("reset idle", 1, o_idle);
		check_equal("reset errcode", core_isa_pkg::ERR_NONE, o_errcode);
		check_equal("reset trace", 8'hff, o_trace);
		run_word(core_isa_pkg::OP_TRACE, core_isa_pkg::OP_NOP);
		check_equal("trace on empty stack", 8'hff, o_trace);
	endtask

	task automatic test_stack();
		int k;
		k = 3 + ($random(seed) & 3);
		for (int i = 0; i < k; i++) begin
			push_value(rand_word());
		end
		run_word(core_isa_pkg::OP_DEPTH, core_isa_pkg::OP_TRACE);
		model.push_back(core_cfg_pkg::word_t'(k));
		check_equal("depth", k, o_trace);
		run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_TRACE);
		void'(model.pop_back());
		check_equal("drop depth", expected_trace(), o_trace);
		run_word(core_isa_pkg::OP_DUP, core_isa_pkg::OP_TRACE);
		model.push_back(model[model.size()-1]);
		check_equal("dup", expected_trace(), o_trace);
		run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_DROP);
		void'(model.pop_back());
		void'(model.pop_back());
		run_word(core_isa_pkg::OP_TRACE, core_isa_pkg::OP_NOP);
		check_equal("drop", expected_trace(), o_trace);
		run_word(core_isa_pkg::OP_EMPTY, core_isa_pkg::OP_TRACE);
		model.delete();
		check_equal("empty", 8'hff, o_trace);
		check_equal("stack errcode", core_isa_pkg::ERR_NONE, o_errcode);
	endtask

	task automatic test_arith();
		logic [6:0] bin_ops [9] = '{core_isa_pkg::OP_ADD, core_isa_pkg::OP_SUB,
			core_isa_pkg::OP_AND, core_isa_pkg::OP_OR, core_isa_pkg::OP_XOR,
			core_isa_pkg::OP_EQ, core_isa_pkg::OP_NEQ, core_isa_pkg::OP_GT, core_isa_pkg::OP_SM};
		logic [6:0] un_ops [4] = '{core_isa_pkg::OP_INC, core_isa_pkg::OP_DEC,
			core_isa_pkg::OP_NOT, core_isa_pkg::OP_COM};
		core_cfg_pkg::word_t a;
		core_cfg_pkg::word_t b;
		core_cfg_pkg::word_t r;
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < 9; i++) begin
				a = rand_word();
				b = (pass == 0) ? rand_word() : a;	// second pass covers equal operands
				push_value(a);
				push_value(b);
				run_word(bin_ops[i], core_isa_pkg::OP_TRACE);
				r = model_result(bin_ops[i], a, b);
				check_equal($sformatf("binary op %0h", bin_ops[i]), r[7:0], o_trace);
				run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_NOP);
				model.delete();
			end
		end
		for (int i = 0; i < 4; i++) begin
			a = rand_word();
			push_value(a);
			run_word(un_ops[i], core_isa_pkg::OP_TRACE);
			r = model_result(un_ops[i], '0, a);
			check_equal($sformatf("unary op %0h", un_ops[i]), r[7:0], o_trace);
			run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_NOP);
			model.delete();
		end
	endtask

	// i_en low in the middle of a word holds the core where it is
	task automatic test_freeze();
		core_cfg_pkg::word_t a;
		core_cfg_pkg::word_t b;
		core_cfg_pkg::word_t r;
		a = rand_word();
		b = rand_word();
		push_value(a);
		push_value(b);
		i_instr.lo = core_isa_pkg::OP_ADD;
		i_instr.hi = core_isa_pkg::OP_TRACE;
		i_instr_en = 1'b1;
		@(posedge clk);
		#1;
		i_instr_en = 1'b0;
		i_en = 1'b0;
		repeat (6) @(posedge clk);
		#1;
		check_equal("frozen idle", 0, o_idle);
		i_en = 1'b1;
		wait_idle();
		r = model_result(core_isa_pkg::OP_ADD, a, b);
		check_equal("add after freeze", r[7:0], o_trace);
		run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_NOP);
		model.delete();
	endtask

	task automatic test_vars_swap();
		core_cfg_pkg::word_t v;
		core_cfg_pkg::word_t idx;
		core_cfg_pkg::word_t t;
		int n;
		int top;
		for (int i = 0; i < 4; i++) begin
			v = rand_word();
			idx = rand_word();		// any index, wraps modulo 8
			var_model[idx[2:0]] = v;
			push_value(v);
			push_value(idx);
			run_word(core_isa_pkg::OP_SETVAR, core_isa_pkg::OP_NOP);
			push_value(core_cfg_pkg::word_t'(idx[2:0]));
			run_word(core_isa_pkg::OP_GETVAR, core_isa_pkg::OP_TRACE);
			check_equal("getvar", var_model[idx[2:0]] & 8'hff, o_trace);
			run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_NOP);
			model.delete();
		end
		// every register, written or still cleared
		for (int j = 0; j < core_cfg_pkg::VREGS; j++) begin
			push_value(core_cfg_pkg::word_t'(j));
			run_word(core_isa_pkg::OP_GETVAR, core_isa_pkg::OP_TRACE);
			check_equal($sformatf("getvar readback %0d", j), var_model[j] & 8'hff, o_trace);
			run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_NOP);
			model.delete();
		end
		for (int i = 0; i < 5; i++) begin
			push_value(rand_word());
		end
		n = 1 + ($random(seed) & 3);
		push_value(core_cfg_pkg::word_t'(n));
		void'(model.pop_back());	// n itself is consumed
		run_word(core_isa_pkg::OP_SWAP, core_isa_pkg::OP_TRACE);
		top = model.size() - 1;
		t = model[top];
		model[top] = model[top-n];
		model[top-n] = t;
		check_equal("swap", expected_trace(), o_trace);
		for (int j = 0; j < n; j++) begin
			run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_TRACE);
			void'(model.pop_back());
			check_equal("swap order", expected_trace(), o_trace);
		end
		run_word(core_isa_pkg::OP_EMPTY, core_isa_pkg::OP_NOP);
		model.delete();
	endtask

	// checks the code, then that a plain NOP word leaves it alone
	task automatic check_error(input string name, input logic [core_isa_pkg::ERR_W-1:0] exp);
		check_equal(name, exp, o_errcode);
		run_word(core_isa_pkg::OP_NOP, core_isa_pkg::OP_NOP);
		check_equal({name, " after nop"}, exp, o_errcode);
	endtask

	task automatic test_errors();
		int n;
		apply_reset();
		run_word(core_isa_pkg::OP_DROP, core_isa_pkg::OP_NOP);
		check_error("drop on empty", core_isa_pkg::ERR_DSEMPTY);
		apply_reset();
		for (int i = 0; i < 9; i++) begin
			push_value(rand_word());
		end
		check_error("ninth push", core_isa_pkg::ERR_DSFULL);
		apply_reset();
		for (int i = 0; i < 3; i++) begin
			push_value(rand_word());
		end
		n = 3 + ($random(seed) & 3);
		push_value(core_cfg_pkg::word_t'(n));
		run_word(core_isa_pkg::OP_SWAP, core_isa_pkg::OP_TRACE);
		check_equal("hi slot dropped", 8'hff, o_trace);
		check_error("swap index", core_isa_pkg::ERR_DSINDEX);
		apply_reset();
		run_word(7'h7f, core_isa_pkg::OP_NOP);
		check_error("invalid opcode", core_isa_pkg::ERR_INVALID);
	endtask

	initial begin
		seed = 32'hdf91_911d;
		rst_n = 1'b0;
		i_en = 1'b1;
		i_push_value = '0;
		i_push_en = 1'b0;
		i_instr = '0;
		i_instr_en = 1'b0;
		test_reset();
		test_stack();
		test_arith();
		test_freeze();
		test_vars_swap();
		test_errors();
		errors += u_core_top.u_sequencer.u_core_sva.fail_count;	// bound assertion failures
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== common/core_cfg_pkg.sv ====
// word type, stack and register sizes, stack command and status structs
package core_cfg_pkg;

	localparam int WORD_W = 56;
	typedef logic [WORD_W-1:0] word_t;	// one stack or register value

	localparam int STACK_DEPTH = 8;
	localparam int STACK_IDX_W = 4;		// wide enough to hold a depth of 8
	localparam int STACK_PTR_W = 3;		// physical slot address inside the stack array

	localparam int VREGS = 8;
	localparam int VREG_IDX_W = 3;

	// actions understood by the data stack
	typedef enum logic [2:0] {
		NONE,
		PUSH,
		POP,
		PEEK,
		POKE,
		CLEAR
	} stack_op_t;

	typedef struct packed {
		stack_op_t op;
		logic [STACK_IDX_W-1:0] index;	// 0 is the top item
		word_t data;					// value for push or poke
	} stack_cmd_t;

	typedef struct packed {
		word_t rdata;					// valid the cycle after pop or peek
		logic full;
		logic empty;
		logic [STACK_IDX_W-1:0] depth;
	} stack_stat_t;

endpackage

// ==== common/core_isa_pkg.sv ====
// opcode values, error codes, trace width and the instruction word struct
package core_isa_pkg;

	localparam int OP_W = 7;

	// stack instructions
	localparam logic [OP_W-1:0] OP_NOP = 7'h00;
	localparam logic [OP_W-1:0] OP_DEPTH = 7'h04;
	localparam logic [OP_W-1:0] OP_EMPTY = 7'h05;
	localparam logic [OP_W-1:0] OP_DUP = 7'h07;
	localparam logic [OP_W-1:0] OP_DROP = 7'h08;
	localparam logic [OP_W-1:0] OP_SWAP = 7'h09;
	localparam logic [OP_W-1:0] OP_TRACE = 7'h0f;

	// variable access
	localparam logic [OP_W-1:0] OP_GETVAR = 7'h14;
	localparam logic [OP_W-1:0] OP_SETVAR = 7'h15;

	// unary arithmetic, operates on the top item
	localparam logic [OP_W-1:0] OP_INC = 7'h18;
	localparam logic [OP_W-1:0] OP_DEC = 7'h19;
	localparam logic [OP_W-1:0] OP_NOT = 7'h1a;
	localparam logic [OP_W-1:0] OP_COM = 7'h1b;

	// binary operations, second item op top item
	localparam logic [OP_W-1:0] OP_ADD = 7'h20;
	localparam logic [OP_W-1:0] OP_SUB = 7'h21;
	localparam logic [OP_W-1:0] OP_AND = 7'h25;
	localparam logic [OP_W-1:0] OP_OR = 7'h26;
	localparam logic [OP_W-1:0] OP_XOR = 7'h27;
	localparam logic [OP_W-1:0] OP_EQ = 7'h28;
	localparam logic [OP_W-1:0] OP_NEQ = 7'h29;
	localparam logic [OP_W-1:0] OP_GT = 7'h2a;
	localparam logic [OP_W-1:0] OP_SM = 7'h2c;

	// two opcodes per word, lo runs first
	typedef struct packed {
		logic [OP_W-1:0] hi;
		logic [OP_W-1:0] lo;
	} instr_t;

	localparam int ERR_W = 9;
	localparam logic [ERR_W-1:0] ERR_NONE = 9'h000;
	localparam logic [ERR_W-1:0] ERR_INVALID = 9'h001;
	localparam logic [ERR_W-1:0] ERR_DSFULL = 9'h004;
	localparam logic [ERR_W-1:0] ERR_DSEMPTY = 9'h005;
	localparam logic [ERR_W-1:0] ERR_DSINDEX = 9'h006;

	localparam int TRACE_W = 8;

endpackage

// ==== sequencer/core_sequencer.sv ====
// FSM that decodes opcodes, walks them through stack steps and checks errors
module core_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic i_en,
	input  core_cfg_pkg::word_t i_push_value,
	input  logic i_push_en,
	input  core_isa_pkg::instr_t i_instr,
	input  logic i_instr_en,
	output core_cfg_pkg::stack_cmd_t o_stack_cmd,
	input  core_cfg_pkg::stack_stat_t i_stack_stat,
	output logic o_var_we,
	output core_cfg_pkg::word_t o_var_idx,
	output core_cfg_pkg::word_t o_var_wdata,
	input  core_cfg_pkg::word_t i_var_rdata,
	output logic [core_isa_pkg::OP_W-1:0] o_alu_op,
	output core_cfg_pkg::word_t o_alu_a,
	output core_cfg_pkg::word_t o_alu_b,
	input  core_cfg_pkg::word_t i_alu_result,
	output logic o_idle,
	output logic [core_isa_pkg::ERR_W-1:0] o_errcode,
	output logic [core_isa_pkg::TRACE_W-1:0] o_trace
);

	typedef enum logic [1:0] {S_IDLE, S_PUSH, S_RUN} state_t;

	state_t state;
	core_isa_pkg::instr_t ir;
	logic slot;				// 0 runs ir.lo, 1 runs ir.hi
	logic [2:0] step;
	core_cfg_pkg::word_t scr_a;
	core_cfg_pkg::word_t scr_b;
	logic var_we;

	logic [core_isa_pkg::OP_W-1:0] opcode;
	core_cfg_pkg::word_t rdata;
	core_cfg_pkg::stack_cmd_t cmd_req;	// wanted command, before the checks
	logic [core_isa_pkg::ERR_W-1:0] err_code;
	logic last, bad_op, wide_idx;
	logic ld_a, ld_b, set_var, trace_ld;

	assign opcode = slot ? ir.hi : ir.lo;
	assign rdata = i_stack_stat.rdata;

	// per-opcode step walk, one stack command per cycle at most
	always_comb begin
		cmd_req = '0;
		last = 1'b0;
		bad_op = 1'b0;
		wide_idx = 1'b0;
		ld_a = 1'b0;
		ld_b = 1'b0;
		set_var = 1'b0;
		trace_ld = 1'b0;
		if (state == S_PUSH) begin
			cmd_req.op = core_cfg_pkg::PUSH;
			cmd_req.data = scr_b;
			last = 1'b1;
		end else if (state == S_RUN) begin
			case (opcode)
				core_isa_pkg::OP_NOP: last = 1'b1;
				core_isa_pkg::OP_DROP: begin
					cmd_req.op = core_cfg_pkg::POP;
					last = 1'b1;
				end
				core_isa_pkg::OP_DEPTH: begin
					cmd_req.op = core_cfg_pkg::PUSH;
					cmd_req.data = core_cfg_pkg::word_t'(i_stack_stat.depth);
					last = 1'b1;
				end
				core_isa_pkg::OP_EMPTY: begin
					cmd_req.op = core_cfg_pkg::CLEAR;
					last = 1'b1;
				end
				core_isa_pkg::OP_DUP: begin
					if (step == 3'd0) begin
						cmd_req.op = core_cfg_pkg::PEEK;
					end else begin
						cmd_req.op = core_cfg_pkg::PUSH;
						cmd_req.data = rdata;
						last = 1'b1;
					end
				end
				core_isa_pkg::OP_TRACE: begin
					if (step != 3'd0 || i_stack_stat.empty) begin
						trace_ld = 1'b1;	// all ones when there is nothing to show
						last = 1'b1;
					end else begin
						cmd_req.op = core_cfg_pkg::PEEK;
					end
				end
				core_isa_pkg::OP_SWAP: begin
					case (step)
						3'd0: cmd_req.op = core_cfg_pkg::POP;	// n
						3'd1: begin
							ld_b = 1'b1;
							if (rdata == '0) begin
								last = 1'b1;	// 0 SWAP does nothing
							end else begin
								cmd_req.op = core_cfg_pkg::PEEK;
								cmd_req.index = rdata[core_cfg_pkg::STACK_IDX_W-1:0];
								wide_idx = |rdata[core_cfg_pkg::WORD_W-1:core_cfg_pkg::STACK_IDX_W];
							end
						end
						3'd2: begin
							ld_a = 1'b1;	// n-th item
							cmd_req.op = core_cfg_pkg::PEEK;
						end
						3'd3: begin
							cmd_req.op = core_cfg_pkg::POKE;
							cmd_req.index = scr_b[core_cfg_pkg::STACK_IDX_W-1:0];
							cmd_req.data = rdata;
						end
						default: begin
							cmd_req.op = core_cfg_pkg::POKE;
							cmd_req.data = scr_a;
							last = 1'b1;
						end
					endcase
				end
				core_isa_pkg::OP_GETVAR,
				core_isa_pkg::OP_INC,
				core_isa_pkg::OP_DEC,
				core_isa_pkg::OP_NOT,
				core_isa_pkg::OP_COM: begin
					case (step)
						3'd0: cmd_req.op = core_cfg_pkg::PEEK;
						3'd1: ld_b = 1'b1;
						default: begin
							cmd_req.op = core_cfg_pkg::POKE;
							cmd_req.data = (opcode == core_isa_pkg::OP_GETVAR) ?
								i_var_rdata : i_alu_result;
							last = 1'b1;
						end
					endcase
				end
				core_isa_pkg::OP_SETVAR: begin
					case (step)
						3'd0: cmd_req.op = core_cfg_pkg::POP;	// index
						3'd1: begin
							ld_b = 1'b1;
							cmd_req.op = core_cfg_pkg::POP;		// value
						end
						3'd2: begin
							ld_a = 1'b1;
							set_var = 1'b1;
						end
						default: last = 1'b1;	// write lands this cycle
					endcase
				end
				core_isa_pkg::OP_ADD,
				core_isa_pkg::OP_SUB,
				core_isa_pkg::OP_AND,
				core_isa_pkg::OP_OR,
				core_isa_pkg::OP_XOR,
				core_isa_pkg::OP_EQ,
				core_isa_pkg::OP_NEQ,
				core_isa_pkg::OP_GT,
				core_isa_pkg::OP_SM: begin
					case (step)
						3'd0: cmd_req.op = core_cfg_pkg::POP;
						3'd1: begin
							ld_b = 1'b1;
							cmd_req.op = core_cfg_pkg::POP;
						end
						default: begin
							cmd_req.op = core_cfg_pkg::PUSH;
							cmd_req.data = i_alu_result;
							last = 1'b1;
						end
					endcase
				end
				default: bad_op = 1'b1;
			endcase
		end
	end

	// checks against the stack state before anything is issued
	always_comb begin
		err_code = core_isa_pkg::ERR_NONE;
		case (cmd_req.op)
			core_cfg_pkg::PUSH: begin
				if (i_stack_stat.full) err_code = core_isa_pkg::ERR_DSFULL;
			end
			core_cfg_pkg::POP: begin
				if (i_stack_stat.empty) err_code = core_isa_pkg::ERR_DSEMPTY;
			end
			core_cfg_pkg::PEEK, core_cfg_pkg::POKE: begin
				if (wide_idx || cmd_req.index >= i_stack_stat.depth)
					err_code = core_isa_pkg::ERR_DSINDEX;
			end
			default: ;
		endcase
		if (bad_op) err_code = core_isa_pkg::ERR_INVALID;
	end

	always_comb begin
		o_stack_cmd = cmd_req;
		if (!i_en || err_code != core_isa_pkg::ERR_NONE) o_stack_cmd.op = core_cfg_pkg::NONE;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			slot <= 1'b0;
			step <= '0;
			var_we <= 1'b0;
			o_errcode <= core_isa_pkg::ERR_NONE;
			o_trace <= '1;
		end else if (i_en) begin
			var_we <= set_var;
			if (ld_a) scr_a <= rdata;
			if (ld_b) scr_b <= rdata;
			if (trace_ld) o_trace <= (step == 3'd0) ? '1 : rdata[core_isa_pkg::TRACE_W-1:0];
			case (state)
				S_IDLE: begin
					if (i_push_en) begin
						scr_b <= i_push_value;
						state <= S_PUSH;
					end else if (i_instr_en) begin
						ir <= i_instr;
						slot <= 1'b0;
						step <= '0;
						state <= S_RUN;
					end
				end
				default: begin
					if (err_code != core_isa_pkg::ERR_NONE) begin
						o_errcode <= err_code;
						state <= S_IDLE;	// rest of the word is dropped
					end else if (last) begin
						if (state == S_RUN && !slot) begin
							slot <= 1'b1;
							step <= '0;
						end else begin
							state <= S_IDLE;
						end
					end else begin
						step <= step + 1'b1;
					end
				end
			endcase
		end
	end

	assign o_var_we = var_we;
	assign o_var_idx = scr_b;
	assign o_var_wdata = scr_a;
	assign o_alu_op = opcode;
	assign o_alu_a = rdata;		// second item, popped last
	assign o_alu_b = scr_b;
	assign o_idle = (state == S_IDLE);

endmodule

// ==== stack/data_stack.sv ====
// data stack storage addressed from the top, with depth and full/empty flags
module data_stack (
	input  logic clk,
	input  logic rst_n,
	input  core_cfg_pkg::stack_cmd_t i_cmd,
	output core_cfg_pkg::stack_stat_t o_stat
);

	core_cfg_pkg::word_t mem [core_cfg_pkg::STACK_DEPTH];
	core_cfg_pkg::word_t rdata;
	logic [core_cfg_pkg::STACK_IDX_W-1:0] depth;	// also the next free slot
	logic [core_cfg_pkg::STACK_IDX_W-1:0] top;		// slot of the top item
	logic [core_cfg_pkg::STACK_IDX_W-1:0] addr;		// slot of the indexed item

	assign top = depth - 1'b1;
	assign addr = top - i_cmd.index;

	// depth moves by one per push or pop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			depth <= '0;
		end else begin
			case (i_cmd.op)
				core_cfg_pkg::PUSH:  depth <= depth + 1'b1;
				core_cfg_pkg::POP:   depth <= depth - 1'b1;
				core_cfg_pkg::CLEAR: depth <= '0;	// whole stack gone in one cycle
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (i_cmd.op)
			core_cfg_pkg::PUSH: mem[depth[core_cfg_pkg::STACK_PTR_W-1:0]] <= i_cmd.data;
			core_cfg_pkg::POKE: mem[addr[core_cfg_pkg::STACK_PTR_W-1:0]] <= i_cmd.data;
			core_cfg_pkg::POP:  rdata <= mem[top[core_cfg_pkg::STACK_PTR_W-1:0]];
			core_cfg_pkg::PEEK: rdata <= mem[addr[core_cfg_pkg::STACK_PTR_W-1:0]];
			default: ;
		endcase
	end

	// no range checks here, the sequencer filters bad commands
	always_comb begin
		o_stat.rdata = rdata;
		o_stat.full = (int'(depth) == core_cfg_pkg::STACK_DEPTH);
		o_stat.empty = (depth == '0);
		o_stat.depth = depth;
	end

endmodule

// ==== verilog/core_alu.sv ====
// combinational evaluation of the unary and binary stack operations
module core_alu (
	input  logic [core_isa_pkg::OP_W-1:0] i_op,
	input  core_cfg_pkg::word_t i_a,	// second item
	input  core_cfg_pkg::word_t i_b,	// top item
	output core_cfg_pkg::word_t o_result
);

	always_comb begin
		case (i_op)
			// unary ops work on the top item
			core_isa_pkg::OP_INC: o_result = i_b + 1'b1;
			core_isa_pkg::OP_DEC: o_result = i_b - 1'b1;
			core_isa_pkg::OP_NOT: o_result = ~i_b;
			core_isa_pkg::OP_COM: o_result = ~i_b + 1'b1;	// two's complement negate

			core_isa_pkg::OP_ADD: o_result = i_a + i_b;
			core_isa_pkg::OP_SUB: o_result = i_a - i_b;
			core_isa_pkg::OP_AND: o_result = i_a & i_b;
			core_isa_pkg::OP_OR:  o_result = i_a | i_b;
			core_isa_pkg::OP_XOR: o_result = i_a ^ i_b;

			// comparisons are unsigned and give 1 or 0
			core_isa_pkg::OP_EQ:  o_result = core_cfg_pkg::word_t'(i_a == i_b);
			core_isa_pkg::OP_NEQ: o_result = core_cfg_pkg::word_t'(i_a != i_b);
			core_isa_pkg::OP_GT:  o_result = core_cfg_pkg::word_t'(i_a > i_b);
			core_isa_pkg::OP_SM:  o_result = core_cfg_pkg::word_t'(i_a < i_b);

			default: o_result = '0;
		endcase
	end

endmodule

// ==== verilog/core_top.sv ====
// core top level joining the sequencer, data stack, variable file and ALU
module core_top (
	input  logic clk,
	input  logic rst_n,
	input  logic i_en,
	input  core_cfg_pkg::word_t i_push_value,
	input  logic i_push_en,
	input  core_isa_pkg::instr_t i_instr,
	input  logic i_instr_en,
	output logic o_idle,
	output logic [core_isa_pkg::ERR_W-1:0] o_errcode,
	output logic [core_isa_pkg::TRACE_W-1:0] o_trace
);

	core_cfg_pkg::stack_cmd_t stack_cmd;
	core_cfg_pkg::stack_stat_t stack_stat;
	logic var_we;
	core_cfg_pkg::word_t var_idx;
	core_cfg_pkg::word_t var_wdata;
	core_cfg_pkg::word_t var_rdata;
	logic [core_isa_pkg::OP_W-1:0] alu_op;
	core_cfg_pkg::word_t alu_a;
	core_cfg_pkg::word_t alu_b;
	core_cfg_pkg::word_t alu_result;

	core_sequencer u_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_en         (i_en),
		.i_push_value (i_push_value),
		.i_push_en    (i_push_en),
		.i_instr      (i_instr),
		.i_instr_en   (i_instr_en),
		.o_stack_cmd  (stack_cmd),
		.i_stack_stat (stack_stat),
		.o_var_we     (var_we),
		.o_var_idx    (var_idx),
		.o_var_wdata  (var_wdata),
		.i_var_rdata  (var_rdata),
		.o_alu_op     (alu_op),
		.o_alu_a      (alu_a),
		.o_alu_b      (alu_b),
		.i_alu_result (alu_result),
		.o_idle       (o_idle),
		.o_errcode    (o_errcode),
		.o_trace      (o_trace)
	);

	data_stack u_data_stack (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_cmd  (stack_cmd),
		.o_stat (stack_stat)
	);

	var_file u_var_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_we    (var_we),
		.i_idx   (var_idx),
		.i_wdata (var_wdata),
		.o_rdata (var_rdata)
	);

	core_alu u_alu (
		.i_op     (alu_op),
		.i_a      (alu_a),
		.i_b      (alu_b),
		.o_result (alu_result)
	);

endmodule

// ==== verilog/var_file.sv ====
// variable register file with one write port and one combinational read port
module var_file (
	input  logic clk,
	input  logic rst_n,
	input  logic i_we,
	input  core_cfg_pkg::word_t i_idx,
	input  core_cfg_pkg::word_t i_wdata,
	output core_cfg_pkg::word_t o_rdata
);

	core_cfg_pkg::word_t regs [core_cfg_pkg::VREGS];
	logic [core_cfg_pkg::VREG_IDX_W-1:0] sel;

	// low bits only, so any index wraps modulo VREGS
	assign sel = i_idx[core_cfg_pkg::VREG_IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < core_cfg_pkg::VREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we) begin
			regs[sel] <= i_wdata;
		end
	end

	assign o_rdata = regs[sel];

endmodule

// ==== vlog.f ====
common/core_cfg_pkg.sv
common/core_isa_pkg.sv
stack/data_stack.sv
verilog/var_file.sv
verilog/core_alu.sv
sequencer/core_sequencer.sv
verilog/core_top.sv
bench/core_sva.sv
bench/tb_core.sv
